/* mist_pkg.sv */
// MiST shell shared constants
package mist_pkg;

	// Command bytes on the board controller SPI link.
	localparam logic [7:0] CMD_BUTTONS = 8'h01;
	localparam logic [7:0] CMD_JOY0    = 8'h02;
	localparam logic [7:0] CMD_JOY1    = 8'h03;
	localparam logic [7:0] CMD_STATUS  = 8'h15;

	// Extended set codes.
	localparam logic [7:0] KEY_RIGHT  = 8'h74;
	localparam logic [7:0] KEY_LEFT   = 8'h6B;
	localparam logic [7:0] KEY_DOWN   = 8'h72;
	localparam logic [7:0] KEY_UP     = 8'h75;
	// Plain set codes.
	localparam logic [7:0] KEY_FIRE   = 8'h29;
	localparam logic [7:0] KEY_START1 = 8'h16;
	localparam logic [7:0] KEY_START2 = 8'h1E;
	localparam logic [7:0] KEY_COIN   = 8'h2E;

	localparam logic [2:0] KBJOY_RIGHT  = 3'd0;
	localparam logic [2:0] KBJOY_LEFT   = 3'd1;
	localparam logic [2:0] KBJOY_DOWN   = 3'd2;
	localparam logic [2:0] KBJOY_UP     = 3'd3;
	localparam logic [2:0] KBJOY_FIRE   = 3'd4;
	localparam logic [2:0] KBJOY_START1 = 3'd5;
	localparam logic [2:0] KBJOY_START2 = 3'd6;
	localparam logic [2:0] KBJOY_COIN   = 3'd7;

	localparam logic [7:0]  PS2_BREAK   = 8'hF0;
	localparam logic [7:0]  PS2_EXTEND  = 8'hE0;
	localparam logic [19:0] PS2_TIMEOUT = 20'd60000;

	localparam int JOY_FIRE   = 4;
	localparam int ST_RESET   = 0;
	localparam int ST_TEST    = 1;
	localparam int ST_SCAN_LO = 3;
	localparam int ST_RESET2  = 6;
	localparam int BTN_RESET  = 1;

	localparam int RESET_HOLD = 16;

	localparam logic [1:0] SCAN_NONE = 2'd0;
	localparam logic [1:0] SCAN_HQ2X = 2'd1;
	localparam logic [1:0] SCAN_25   = 2'd2;
	localparam logic [1:0] SCAN_50   = 2'd3;

	localparam int AUDIO_W = 7;
	localparam int DAC_W   = 8;

endpackage

/* user_io.sv */
// Board controller SPI receiver
`timescale 1ns/100ps
module user_io
	import mist_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        spi_sck,
	input  logic        spi_ss,
	input  logic        spi_di,
	output logic [31:0] status,
	output logic [1:0]  buttons,
	output logic [7:0]  joy0,
	output logic [7:0]  joy1
);

	logic       sck_meta, sck_s, sck_d;
	logic       ss_meta, ss_s;
	logic       di_meta, di_s;
	logic       sck_rise;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic       byte_rdy;
	logic [2:0] byte_cnt;
	logic       rx_stb;
	logic       rx_first;
	logic [2:0] rx_idx;
	logic [7:0] rx_byte;
	logic [7:0] cmd;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			{sck_meta, sck_s, sck_d} <= 3'b000;
			{ss_meta, ss_s} <= 2'b11;
			{di_meta, di_s} <= 2'b00;
		end else begin
			{sck_meta, sck_s, sck_d} <= {spi_sck, sck_meta, sck_s};
			{ss_meta, ss_s} <= {spi_ss, ss_meta};
			{di_meta, di_s} <= {spi_di, di_meta};
		end
	end

	assign sck_rise = sck_s & ~sck_d;

	// Bit counter restarts whenever the slave is deselected.
	always_ff @(posedge clk_sys) begin
		if (rst || ss_s) begin
			bit_cnt <= '0;
			byte_rdy <= 1'b0;
		end else begin
			byte_rdy <= sck_rise && (bit_cnt == 3'd7);
			if (sck_rise)
				bit_cnt <= bit_cnt + 3'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sck_rise)
			shift <= {shift[6:0], di_s};
	end

	// Byte index within the frame, saturating.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			byte_cnt <= '0;
			rx_stb <= 1'b0;
		end else begin
			rx_stb <= byte_rdy;
			if (ss_s)
				byte_cnt <= '0;
			else if (byte_rdy && byte_cnt != 3'd7)
				byte_cnt <= byte_cnt + 3'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_rdy) begin
			rx_byte <= shift;
			rx_first <= (byte_cnt == 3'd0);
			rx_idx <= byte_cnt - 3'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cmd <= '0;
			status <= '0;
			buttons <= '0;
			joy0 <= '0;
			joy1 <= '0;
		end else if (rx_stb) begin
			if (rx_first) begin
				cmd <= rx_byte;
			end else begin
				case (cmd)
					CMD_BUTTONS: if (rx_idx == 3'd0) buttons <= rx_byte[1:0];
					CMD_JOY0:    if (rx_idx == 3'd0) joy0 <= rx_byte;
					CMD_JOY1:    if (rx_idx == 3'd0) joy1 <= rx_byte;
					CMD_STATUS:  if (rx_idx < 3'd4) status[{rx_idx[1:0], 3'b000} +: 8] <= rx_byte;
					default: ;
				endcase
			end
		end
	end

endmodule

/* ps2_keyboard.sv */
// PS/2 keyboard to game keys
`timescale 1ns/100ps
module ps2_keyboard
	import mist_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] kbjoy
);

	logic        clk_meta, clk_s, clk_d;
	logic        data_meta, data_s;
	logic        clk_fall;
	logic [3:0]  bit_cnt;
	logic [9:0]  frame;
	logic [10:0] full;
	logic        frame_done;
	logic        frame_ok;
	logic [7:0]  code;
	logic [19:0] idle_cnt;
	logic        brk, ext;
	logic        key_hit;
	logic [2:0]  key_bit;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			{clk_meta, clk_s, clk_d} <= 3'b111;
			{data_meta, data_s} <= 2'b11;
		end else begin
			{clk_meta, clk_s, clk_d} <= {ps2_clk, clk_meta, clk_s};
			{data_meta, data_s} <= {ps2_data, data_meta};
		end
	end

	assign clk_fall = clk_d & ~clk_s;
	assign frame_done = clk_fall && (bit_cnt == 4'd10);
	// Stop bit is taken straight from the line.
	assign full = {data_s, frame};
	assign code = full[8:1];
	assign frame_ok = !full[0] && full[10] && (^full[9:1]);

	always_ff @(posedge clk_sys) begin
		if (clk_fall)
			frame <= {data_s, frame[9:1]};
	end

	// Watchdog drops a frame that stalls part way.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			bit_cnt <= '0;
			idle_cnt <= '0;
		end else if (clk_fall) begin
			idle_cnt <= '0;
			bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
		end else if (bit_cnt != 4'd0) begin
			if (idle_cnt == PS2_TIMEOUT) begin
				bit_cnt <= '0;
				idle_cnt <= '0;
			end else begin
				idle_cnt <= idle_cnt + 20'd1;
			end
		end
	end

	always_comb begin
		key_hit = 1'b1;
		key_bit = KBJOY_RIGHT;
		if (ext) begin
			case (code)
				KEY_RIGHT: key_bit = KBJOY_RIGHT;
				KEY_LEFT:  key_bit = KBJOY_LEFT;
				KEY_DOWN:  key_bit = KBJOY_DOWN;
				KEY_UP:    key_bit = KBJOY_UP;
				default:   key_hit = 1'b0;
			endcase
		end else begin
			case (code)
				KEY_FIRE:   key_bit = KBJOY_FIRE;
				KEY_START1: key_bit = KBJOY_START1;
				KEY_START2: key_bit = KBJOY_START2;
				KEY_COIN:   key_bit = KBJOY_COIN;
				default:    key_hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			kbjoy <= '0;
			brk <= 1'b0;
			ext <= 1'b0;
		end else if (frame_done && frame_ok) begin
			if (code == PS2_BREAK) begin
				brk <= 1'b1;
			end else if (code == PS2_EXTEND) begin
				ext <= 1'b1;
			end else begin
				brk <= 1'b0;
				ext <= 1'b0;
				if (key_hit)
					kbjoy[key_bit] <= ~brk;
			end
		end
	end

endmodule

/* player_controls.sv */
// Cabinet inputs and core reset
`timescale 1ns/100ps
module player_controls
	import mist_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  logic [31:0] status,
	input  logic [1:0]  buttons,
	input  logic [7:0]  joy0,
	input  logic [7:0]  joy1,
	input  logic [7:0]  kbjoy,
	output logic        core_reset_n,
	output logic        core_coin1,
	output logic        core_start1,
	output logic        core_start2,
	output logic        core_fire1,
	output logic        core_test
);

	localparam int HOLD_W = $clog2(RESET_HOLD + 1);

	logic              reset_req;
	logic [HOLD_W-1:0] hold_cnt;

	assign reset_req = status[ST_RESET] | status[ST_RESET2] | buttons[BTN_RESET];

	// Reset stays low for RESET_HOLD cycles after the last request.
	always_ff @(posedge clk_sys) begin
		if (rst || reset_req) begin
			hold_cnt <= HOLD_W'(RESET_HOLD);
			core_reset_n <= 1'b0;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
			core_reset_n <= 1'b0;
		end else begin
			core_reset_n <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			core_coin1 <= 1'b1;
			core_start1 <= 1'b1;
			core_start2 <= 1'b1;
			core_fire1 <= 1'b1;
			core_test <= 1'b1;
		end else begin
			core_coin1 <= ~kbjoy[KBJOY_COIN];
			core_start1 <= ~kbjoy[KBJOY_START1];
			core_start2 <= ~kbjoy[KBJOY_START2];
			core_fire1 <= ~(kbjoy[KBJOY_FIRE] | joy0[JOY_FIRE] | joy1[JOY_FIRE]);
			core_test <= ~status[ST_TEST];
		end
	end

endmodule

/* video_mixer.sv */
// Blanking and scanline mixer
`timescale 1ns/100ps
module video_mixer
	import mist_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       core_ce_pix,
	input  logic       core_hb,
	input  logic       core_vb,
	input  logic       core_hs,
	input  logic       core_vs,
	input  logic [7:0] core_rgb,
	input  logic [1:0] scan_mode,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic [5:0] base;
	logic [5:0] dimmed;
	logic [5:0] pix_q;
	logic       odd_line;
	logic       odd_nxt;

	// Parity counts hs rising edges, the previous sample is vga_hs.
	always_comb begin
		base = core_rgb[7:2];
		if (core_vs)
			odd_nxt = 1'b0;
		else if (core_hs && !vga_hs)
			odd_nxt = ~odd_line;
		else
			odd_nxt = odd_line;
		dimmed = base;
		case (scan_mode)
			SCAN_25:              if (odd_nxt) dimmed = base - (base >> 2);
			SCAN_50:              if (odd_nxt) dimmed = base >> 1;
			SCAN_NONE, SCAN_HQ2X: dimmed = base;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pix_q <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			odd_line <= 1'b0;
		end else if (core_ce_pix) begin
			pix_q <= (core_hb | core_vb) ? 6'd0 : dimmed;
			vga_hs <= core_hs;
			vga_vs <= core_vs;
			odd_line <= odd_nxt;
		end
	end

	// Mono core.
	assign vga_r = pix_q;
	assign vga_g = pix_q;
	assign vga_b = pix_q;

endmodule

/* sigma_delta_dac.sv */
// First-order sigma-delta DAC
`timescale 1ns/100ps
module sigma_delta_dac
	import mist_pkg::*;
(
	input  logic               clk_sys,
	input  logic               rst,
	input  logic [AUDIO_W-1:0] audio1,
	input  logic [AUDIO_W-1:0] audio2,
	output logic               dac_out
);

	logic [DAC_W-1:0] sum;
	logic [DAC_W:0]   acc;

	assign sum = DAC_W'(audio1) + DAC_W'(audio2);

	// Carry out of the accumulator is the pulse density output.
	always_ff @(posedge clk_sys) begin
		if (rst)
			acc <= '0;
		else
			acc <= {1'b0, acc[DAC_W-1:0]} + {1'b0, sum};
	end

	assign dac_out = acc[DAC_W];

endmodule

/* arcade_mist_top.sv */
// Arcade board shell top
`timescale 1ns/100ps
module arcade_mist_top
	import mist_pkg::*;
(
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               spi_sck,
	input  logic               spi_ss,
	input  logic               spi_di,
	input  logic               ps2_clk,
	input  logic               ps2_data,
	input  logic               core_ce_pix,
	input  logic [7:0]         core_rgb,
	input  logic               core_hb,
	input  logic               core_vb,
	input  logic               core_hs,
	input  logic               core_vs,
	input  logic [AUDIO_W-1:0] core_audio1,
	input  logic [AUDIO_W-1:0] core_audio2,
	output logic               core_reset_n,
	output logic               core_coin1,
	output logic               core_start1,
	output logic               core_start2,
	output logic               core_fire1,
	output logic               core_test,
	output logic [5:0]         vga_r,
	output logic [5:0]         vga_g,
	output logic [5:0]         vga_b,
	output logic               vga_hs,
	output logic               vga_vs,
	output logic               audio_l,
	output logic               audio_r
);

	logic [31:0] status;
	logic [1:0]  buttons;
	logic [7:0]  joy0, joy1;
	logic [7:0]  kbjoy;
	logic        dac_bit;

	user_io user_io_i (.clk_sys, .rst, .spi_sck, .spi_ss, .spi_di, .status, .buttons, .joy0, .joy1);

	ps2_keyboard ps2_keyboard_i (.clk_sys, .rst, .ps2_clk, .ps2_data, .kbjoy);

	player_controls player_controls_i (.clk_sys, .rst, .status, .buttons, .joy0, .joy1, .kbjoy,
		.core_reset_n, .core_coin1, .core_start1, .core_start2, .core_fire1, .core_test);

	video_mixer video_mixer_i (.clk_sys, .rst, .core_ce_pix, .core_hb, .core_vb, .core_hs,
		.core_vs, .core_rgb, .scan_mode(status[ST_SCAN_LO +: 2]),
		.vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs);

	sigma_delta_dac dac_i (.clk_sys, .rst, .audio1(core_audio1), .audio2(core_audio2),
		.dac_out(dac_bit));

	// Both channels carry the mixed audio.
	assign audio_l = dac_bit;
	assign audio_r = dac_bit;

endmodule

/* arcade_mist_assertions.sv */
// Arcade shell port checker
`timescale 1ns/100ps
module arcade_mist_assertions
	import mist_pkg::*;
(
	input logic               clk_sys,
	input logic               rst,
	input logic               core_ce_pix,
	input logic [7:0]         core_rgb,
	input logic               core_hb,
	input logic               core_vb,
	input logic               core_hs,
	input logic               core_vs,
	input logic [AUDIO_W-1:0] core_audio1,
	input logic [AUDIO_W-1:0] core_audio2,
	input logic               core_reset_n,
	input logic [5:0]         vga_r,
	input logic [5:0]         vga_g,
	input logic [5:0]         vga_b,
	input logic               vga_hs,
	input logic               vga_vs,
	input logic               audio_l,
	input logic               audio_r,
	input logic [31:0]        status,
	input logic [1:0]         buttons,
	input logic [1:0]         scan_mode
);

	int               error_count = 0;
	logic             reset_req;
	logic [7:0]       line_no;
	logic [7:0]       line_next;
	logic [5:0]       exp_pix;
	logic [DAC_W-1:0] sum_now, sum_q, win_sum;
	logic [9:0]       stable_cnt;
	logic [7:0]       win_cnt;
	logic [8:0]       ones, win_ones;
	logic             win_done;

	function automatic logic [5:0] shade(input logic [7:0] rgb, input logic [1:0] mode,
		input logic odd);
		int b;
		b = rgb[7:2];
		if (odd && mode == SCAN_50)
			return 6'(b / 2);
		if (odd && mode == SCAN_25)
			return 6'(b - b / 4);
		return 6'(b);
	endfunction

	// Any of the three reset requests.
	assign reset_req = status[ST_RESET] | status[ST_RESET2] | buttons[BTN_RESET];

	// Lines counted from the registered hs rising edge, cleared in vsync.
	assign line_next = core_vs ? 8'd0 : (core_hs && !vga_hs) ? line_no + 8'd1 : line_no;
	assign exp_pix = shade(core_rgb, scan_mode, line_next[0]);
	assign sum_now = DAC_W'(core_audio1) + DAC_W'(core_audio2);

	always_ff @(posedge clk_sys) begin
		if (rst)
			line_no <= '0;
		else if (core_ce_pix)
			line_no <= line_next;
	end

	// Ones on audio_l per 256-cycle window, valid only for a settled sum.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sum_q <= '0;
			win_sum <= '0;
			stable_cnt <= '0;
			win_cnt <= '0;
			ones <= '0;
			win_ones <= '0;
			win_done <= 1'b0;
		end else begin
			sum_q <= sum_now;
			if (sum_now != sum_q)
				stable_cnt <= '0;
			else if (stable_cnt != 10'h3ff)
				stable_cnt <= stable_cnt + 10'd1;
			win_cnt <= win_cnt + 8'd1;
			win_done <= (win_cnt == 8'hff) && (stable_cnt > 10'd300);
			if (win_cnt == 8'hff) begin
				win_ones <= ones + 9'(audio_l);
				win_sum <= sum_q;
				ones <= '0;
			end else begin
				ones <= ones + 9'(audio_l);
			end
		end
	end

	// Low for RESET_HOLD cycles once the cleared request reaches the output, then high.
	reset_hold_a: assert property (@(posedge clk_sys) disable iff (rst)
		$fell(reset_req) |=> !core_reset_n [*RESET_HOLD] ##1 (core_reset_n || reset_req))
		else begin
			error_count = error_count + 1;
			$error("Core reset hold after the last request has the wrong length.");
		end

	blank_a: assert property (@(posedge clk_sys) disable iff (rst)
		core_ce_pix && (core_hb || core_vb) |=> vga_r == 6'd0 && vga_g == 6'd0 && vga_b == 6'd0)
		else begin
			error_count = error_count + 1;
			$error("Colors not zero after a blanked pixel.");
		end

	pixel_a: assert property (@(posedge clk_sys) disable iff (rst)
		core_ce_pix && !core_hb && !core_vb
		|=> vga_r == $past(exp_pix) && vga_g == vga_r && vga_b == vga_r)
		else begin
			error_count = error_count + 1;
			$error("Pixel color differs from the scanline rule.");
		end

	sync_a: assert property (@(posedge clk_sys) disable iff (rst)
		core_ce_pix |=> vga_hs == $past(core_hs) && vga_vs == $past(core_vs))
		else begin
			error_count = error_count + 1;
			$error("Syncs do not follow the sampled core syncs.");
		end

	density_a: assert property (@(posedge clk_sys) disable iff (rst)
		win_done |-> win_ones == 9'(win_sum) || win_ones == 9'(win_sum) + 9'd1)
		else begin
			error_count = error_count + 1;
			$error("DAC density out of range.");
		end

	stereo_a: assert property (@(posedge clk_sys) disable iff (rst) audio_r == audio_l)
		else begin
			error_count = error_count + 1;
			$error("audio_r differs from audio_l.");
		end

endmodule

bind arcade_mist_top arcade_mist_assertions assertions_i (.*,
	.scan_mode(status[ST_SCAN_LO +: 2]));

/* tb_arcade_mist.sv */
// Arcade shell testbench
`timescale 1ns/100ps
module tb_arcade_mist
	import mist_pkg::*;
();

	logic               clk_sys, rst;
	logic               spi_sck, spi_ss, spi_di, ps2_clk, ps2_data;
	logic               core_ce_pix, core_hb, core_vb, core_hs, core_vs;
	logic [7:0]         core_rgb;
	logic [AUDIO_W-1:0] core_audio1, core_audio2;
	logic               core_reset_n, core_coin1, core_start1, core_start2;
	logic               core_fire1, core_test;
	logic [5:0]         vga_r, vga_g, vga_b;
	logic               vga_hs, vga_vs, audio_l, audio_r;
	integer             seed;
	int                 pix_cnt, line_cnt;
	logic [7:0]         kb_m, joy0_m, joy1_m;
	logic [31:0]        status_m;
	logic               reset_n_m;

	arcade_mist_top dut_i (.*);

	always #10 clk_sys = ~clk_sys;

	// Raster of 40 pixels by 12 lines, a pixel every second cycle.
	always @(posedge clk_sys) begin
		#2;
		core_ce_pix = ~core_ce_pix;
		if (core_ce_pix) begin
			pix_cnt = (pix_cnt == 39) ? 0 : pix_cnt + 1;
			if (pix_cnt == 0)
				line_cnt = (line_cnt == 11) ? 0 : line_cnt + 1;
			core_rgb = $random(seed);
			core_hb = pix_cnt >= 30;
			core_hs = pix_cnt >= 32 && pix_cnt < 36;
			core_vb = line_cnt >= 9;
			core_vs = line_cnt >= 10;
		end
	end

	always @(negedge clk_sys) begin
		if (dut_i.assertions_i.error_count != 0)
			fail_run("A concurrent assertion on the DUT ports failed.");
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first failure.");
	endtask

	task automatic step(input int n);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	function automatic logic [5:0] cabinet_now();
		return {core_reset_n, core_coin1, core_start1, core_start2, core_fire1, core_test};
	endfunction

	// Active-low cabinet inputs expected from the control sources.
	function automatic logic [5:0] cabinet_exp();
		return {reset_n_m, ~kb_m[KBJOY_COIN], ~kb_m[KBJOY_START1], ~kb_m[KBJOY_START2],
			~(kb_m[KBJOY_FIRE] | joy0_m[JOY_FIRE] | joy1_m[JOY_FIRE]), ~status_m[ST_TEST]};
	endfunction

	task automatic check_cabinet(input string what);
		if (cabinet_now() !== cabinet_exp()) begin
			$display("Mismatch cabinet {reset_n,coin1,start1,start2,fire1,test}: got %h expected %h",
				cabinet_now(), cabinet_exp());
			fail_run({"Cabinet inputs wrong after ", what, "."});
		end
	endtask

	task automatic settle_cabinet(input string what);
		int n;
		n = 0;
		while (cabinet_now() !== cabinet_exp() && n < 400) begin
			n++;
			step(1);
		end
		if (cabinet_now() !== cabinet_exp())
			$display("Timeout waiting for the cabinet inputs after %s.", what);
		check_cabinet(what);
		step(20);
		check_cabinet(what);
	endtask

	task automatic spi_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			spi_di = b[i];
			step(5);
			spi_sck = 1'b1;
			step(5);
			spi_sck = 1'b0;
		end
	endtask

	task automatic spi_send(input logic [7:0] cmd, input logic [31:0] data, input int nbytes);
		spi_ss = 1'b0;
		step(5);
		spi_byte(cmd);
		for (int i = 0; i < nbytes; i++)
			spi_byte(data[8*i +: 8]);
		step(5);
		spi_ss = 1'b1;
		step(10);
	endtask

	task automatic send_status(input logic [31:0] st);
		status_m = st;
		spi_send(CMD_STATUS, st, 4);
	endtask

	task automatic send_joy(input logic [7:0] cmd, input logic [7:0] v);
		if (cmd == CMD_JOY0)
			joy0_m = v;
		else
			joy1_m = v;
		spi_send(cmd, {24'h0, v}, 1);
	endtask

	// Start, data LSB first, odd parity, stop.
	task automatic ps2_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			step(4);
			ps2_clk = 1'b0;
			step(4);
			ps2_clk = 1'b1;
		end
		step(4);
		ps2_data = 1'b1;
		step(8);
	endtask

	task automatic key_event(input logic [7:0] code, input logic [2:0] kbit, input logic brk,
		input string what);
		if (brk)
			ps2_frame(PS2_BREAK, 1'b0);
		ps2_frame(code, 1'b0);
		kb_m[kbit] = !brk;
		settle_cabinet(what);
	endtask

	task automatic measure_reset_hold();
		int n;
		int t;
		t = 0;
		n = 0;
		while (dut_i.status[ST_RESET] !== 1'b0 && t < 2000) begin
			t++;
			step(1);
		end
		if (t == 2000)
			fail_run("Timeout waiting for the reset request to clear.");
		step(1);
		while (core_reset_n === 1'b0 && n < 100) begin
			n++;
			step(1);
		end
		if (n != RESET_HOLD) begin
			$display("Mismatch core_reset_n hold cycles: got %h expected %h", n, RESET_HOLD);
			fail_run("Core reset hold has the wrong length.");
		end
	endtask

	initial begin
		seed = 32'h19d4_59d0;
		clk_sys = 1'b0;
		rst = 1'b1;
		{spi_sck, spi_di, spi_ss} = 3'b001;
		{ps2_clk, ps2_data} = 2'b11;
		{core_ce_pix, core_hb, core_vb, core_hs, core_vs} = 5'b0;
		core_rgb = 8'h00;
		core_audio1 = 7'd20;
		core_audio2 = 7'd33;
		{kb_m, joy0_m, joy1_m, status_m} = '0;
		reset_n_m = 1'b1;
		pix_cnt = 0;
		line_cnt = 0;
		repeat (3) @(posedge clk_sys);
		#2;
		rst = 1'b0;
		settle_cabinet("reset release");

		send_status(32'h2);
		settle_cabinet("test switch on");
		send_status(32'h0);
		settle_cabinet("test switch off");
		reset_n_m = 1'b0;
		send_status(32'h1);
		settle_cabinet("status reset request");
		fork
			send_status(32'h0);
			measure_reset_hold();
		join
		reset_n_m = 1'b1;
		settle_cabinet("reset request cleared");

		key_event(KEY_FIRE, KBJOY_FIRE, 1'b0, "fire make");
		key_event(KEY_FIRE, KBJOY_FIRE, 1'b1, "fire break");
		key_event(KEY_START1, KBJOY_START1, 1'b0, "start1 make");
		key_event(KEY_START1, KBJOY_START1, 1'b1, "start1 break");
		key_event(KEY_START2, KBJOY_START2, 1'b0, "start2 make");
		key_event(KEY_START2, KBJOY_START2, 1'b1, "start2 break");
		key_event(KEY_COIN, KBJOY_COIN, 1'b0, "coin make");
		key_event(KEY_COIN, KBJOY_COIN, 1'b1, "coin break");
		// A coin make with bad parity must be dropped.
		ps2_frame(KEY_COIN, 1'b1);
		step(20);
		check_cabinet("bad parity frame");
		send_joy(CMD_JOY0, 8'h10);
		settle_cabinet("joystick 0 fire");
		send_joy(CMD_JOY0, 8'h00);
		settle_cabinet("joystick 0 release");
		send_joy(CMD_JOY1, 8'h10);
		settle_cabinet("joystick 1 fire");
		send_joy(CMD_JOY1, 8'h00);
		settle_cabinet("joystick 1 release");

		// Scanline modes with a different constant audio sum each.
		{core_audio1, core_audio2} = {7'd127, 7'd127};
		send_status(32'(SCAN_NONE) << ST_SCAN_LO);
		step(1200);
		{core_audio1, core_audio2} = {7'd0, 7'd0};
		send_status(32'(SCAN_50) << ST_SCAN_LO);
		step(1200);
		{core_audio1, core_audio2} = {7'd1, 7'd0};
		send_status(32'(SCAN_25) << ST_SCAN_LO);
		step(1200);
		{core_audio1, core_audio2} = {7'd64, 7'd63};
		send_status(32'(SCAN_HQ2X) << ST_SCAN_LO);
		step(1200);
		check_cabinet("scanline modes");

		if (dut_i.assertions_i.error_count != 0) begin
			fail_run("A concurrent assertion failed during the run.");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

/* filelist.f */
mist_pkg.sv
user_io.sv
ps2_keyboard.sv
player_controls.sv
video_mixer.sv
sigma_delta_dac.sv
arcade_mist_top.sv
arcade_mist_assertions.sv
tb_arcade_mist.sv

/* Bender.yml */
package:
  name: arcade_mist

sources:
  - mist_pkg.sv
  - user_io.sv
  - ps2_keyboard.sv
  - player_controls.sv
  - video_mixer.sv
  - sigma_delta_dac.sv
  - arcade_mist_top.sv
  - target: test
    files:
      - arcade_mist_assertions.sv
      - tb_arcade_mist.sv
